//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module sdram_peri_tb -Mdir obj_dir -f sdram_peri.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed"
	exit "$status"
fi

./obj_dir/Vsdram_peri_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit "$status"
fi

echo "simulation finished"
exit 0

//--- sdram_peri.f
src/sdram_peri_pkg.sv
src/sdram_peri_if.sv
src/peri_regs.sv
src/xfer_buffer.sv
src/xfer_seq.sv
src/sdram_peri.sv
verif/sdram_peri_assert.sv
verif/sdram_peri_tb.sv

//--- src/peri_regs.sv
`default_nettype none
`timescale 1ns/10ps

module peri_regs #(
	parameter int BLOCK_SEL = 1
) (
	input logic clk,
	input logic rst_n,
	// peripheral bus
	input logic [sdram_peri_pkg::BUS_ADR_W-1:0] adr,
	input logic we,
	input logic [sdram_peri_pkg::BUS_DAT_W-1:0] dat_w,
	output logic [sdram_peri_pkg::BUS_DAT_W-1:0] dat_r,
	// request address, written by lanes, read as a word
	output sdram_peri_pkg::word_u req_addr,
	buf_bus_if.regs bus,
	ctl_if.regs ctl
);
	import sdram_peri_pkg::*;

	localparam int BLK_W = BUS_ADR_W - OFS_W;

	logic sel;
	logic [OFS_W-1:0] ofs;
	logic wr_en;
	logic rd_en;
	// lane numbers for the two four-byte windows
	logic [1:0] addr_lane;
	logic [1:0] data_lane;
	logic [LEN_W-1:0] len_q;
	logic [BUS_DAT_W-1:0] rd_mux;

	// upper bits pick the block
	assign sel = (adr[BUS_ADR_W-1:OFS_W] == BLK_W'(BLOCK_SEL));
	assign ofs = adr[OFS_W-1:0];
	assign wr_en = sel && we;
	assign rd_en = sel && !we;

	assign addr_lane = 2'(ofs - REG_ADDR0);
	assign data_lane = 2'(ofs - REG_DATA0);

	// data lane writes go straight to the buffer word at the pointer
	assign bus.lane_we = wr_en && (ofs inside {[REG_DATA0:REG_DATA3]});
	assign bus.lane_sel = data_lane;
	assign bus.lane_data = dat_w;

	// pointer load from REG_PTR, or cleared by an accepted command
	always_comb begin
		bus.ptr_we = 1'b0;
		bus.ptr_data = dat_w;
		if (wr_en && ofs == REG_PTR) begin
			bus.ptr_we = 1'b1;
		end
		else if (wr_en && ofs == REG_CMD && ctl.state == IDLE) begin
			bus.ptr_we = 1'b1;
			bus.ptr_data = '0;
		end
	end

	// command pulse, sequencer only takes it in IDLE
	assign ctl.start = wr_en && (ofs == REG_CMD);
	// zero means write, anything else read
	assign ctl.is_read = |dat_w;
	assign ctl.len = len_q;

	// setup registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_addr <= '0;
			len_q <= '0;
		end
		else if (wr_en) begin
			case (ofs)
				REG_ADDR0, REG_ADDR1, REG_ADDR2, REG_ADDR3: begin
					req_addr.lane[addr_lane] <= dat_w;
				end
				REG_LEN: begin
					len_q <= dat_w;
				end
				default: begin
				end
			endcase
		end
	end

	// read-back select
	always_comb begin
		case (ofs)
			REG_STATUS: rd_mux = BUS_DAT_W'(ctl.state);
			REG_ADDR0, REG_ADDR1, REG_ADDR2, REG_ADDR3: rd_mux = req_addr.lane[addr_lane];
			// byte of the word at the pointer
			REG_DATA0, REG_DATA1, REG_DATA2, REG_DATA3: rd_mux = bus.cur_word.lane[data_lane];
			REG_PTR: rd_mux = bus.ptr;
			REG_LEN: rd_mux = len_q;
			default: rd_mux = '0;
		endcase
	end

	// dat_r only moves on a selected read, holds otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dat_r <= '0;
		end
		else if (rd_en) begin
			dat_r <= rd_mux;
		end
	end

endmodule

`default_nettype wire

//--- src/sdram_peri.sv
`default_nettype none
`timescale 1ns/10ps

module sdram_peri #(
	parameter int BLOCK_SEL = 1,
	parameter int BUF_DEPTH = 32
) (
	input logic clk,
	input logic rst_n,
	// peripheral bus
	input logic [sdram_peri_pkg::BUS_ADR_W-1:0] adr,
	input logic we,
	input logic [sdram_peri_pkg::BUS_DAT_W-1:0] dat_w,
	output logic [sdram_peri_pkg::BUS_DAT_W-1:0] dat_r,
	// memory controller app port
	output logic app_req,
	input logic app_req_ack,
	output logic app_req_wr_n,
	output logic [sdram_peri_pkg::WORD_W-1:0] app_req_addr,
	output logic [sdram_peri_pkg::LEN_W-1:0] app_req_len,
	output logic [sdram_peri_pkg::WORD_W-1:0] app_wr_data,
	input logic app_wr_next_req,
	input logic [sdram_peri_pkg::WORD_W-1:0] app_rd_data,
	input logic app_rd_valid
);

	buf_bus_if bus_if ();
	buf_xfer_if xfer_if ();
	ctl_if ctl ();

	// length straight from the setup register
	assign app_req_len = ctl.len;
	// write data is always the word at the pointer
	assign app_wr_data = xfer_if.cur_word;

	peri_regs #(
		.BLOCK_SEL(BLOCK_SEL)
	) i_regs (
		.clk(clk),
		.rst_n(rst_n),
		.adr(adr),
		.we(we),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.req_addr(app_req_addr),
		.bus(bus_if.regs),
		.ctl(ctl.regs)
	);

	xfer_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus_if.buffer),
		.xfer(xfer_if.buffer)
	);

	xfer_seq i_seq (
		.clk(clk),
		.rst_n(rst_n),
		.ctl(ctl.seq),
		.xfer(xfer_if.seq),
		.app_req(app_req),
		.app_req_ack(app_req_ack),
		.app_req_wr_n(app_req_wr_n),
		.app_wr_next_req(app_wr_next_req),
		.app_rd_data(app_rd_data),
		.app_rd_valid(app_rd_valid)
	);

endmodule

`default_nettype wire

//--- src/sdram_peri_if.sv
`default_nettype none
`timescale 1ns/10ps

// register block to transfer buffer
interface buf_bus_if;
	import sdram_peri_pkg::*;

	// byte write into one lane of the word at the pointer
	logic lane_we;
	logic [1:0] lane_sel;
	logic [BUS_DAT_W-1:0] lane_data;
	// pointer load
	logic ptr_we;
	logic [LEN_W-1:0] ptr_data;
	// returned by the buffer
	word_u cur_word;
	logic [LEN_W-1:0] ptr;

	modport regs (
		output lane_we, lane_sel, lane_data, ptr_we, ptr_data,
		input cur_word, ptr
	);
	modport buffer (
		input lane_we, lane_sel, lane_data, ptr_we, ptr_data,
		output cur_word, ptr
	);
endinterface

// sequencer to transfer buffer
interface buf_xfer_if;
	import sdram_peri_pkg::*;

	// advance pointer on a write transfer
	logic step;
	// store a returned word, then advance
	logic fill_we;
	logic [WORD_W-1:0] fill_data;
	// word at pointer, feeds app write data
	logic [WORD_W-1:0] cur_word;
	logic [LEN_W-1:0] ptr;

	modport seq (
		output step, fill_we, fill_data,
		input cur_word, ptr
	);
	modport buffer (
		input step, fill_we, fill_data,
		output cur_word, ptr
	);
endinterface

// register block to sequencer
interface ctl_if;
	import sdram_peri_pkg::*;

	// one-cycle pulse on a command write
	logic start;
	// nonzero command byte
	logic is_read;
	logic [LEN_W-1:0] len;
	// for status read-back
	seq_state_e state;

	modport regs (
		output start, is_read, len,
		input state
	);
	modport seq (
		input start, is_read, len,
		output state
	);
endinterface

`default_nettype wire

//--- src/sdram_peri_pkg.sv
`default_nettype none

package sdram_peri_pkg;

	// peripheral bus geometry
	localparam int BUS_ADR_W = 14;
	localparam int BUS_DAT_W = 8;
	// low address bits that pick a register inside the block
	localparam int OFS_W = 9;

	// buffer word, app data and request address width
	localparam int WORD_W = 32;
	// word count and buffer pointer width
	localparam int LEN_W = 8;

	// register offsets
	localparam logic [OFS_W-1:0] REG_STATUS = 9'd0;
	localparam logic [OFS_W-1:0] REG_ADDR0 = 9'd1;
	localparam logic [OFS_W-1:0] REG_ADDR1 = 9'd2;
	localparam logic [OFS_W-1:0] REG_ADDR2 = 9'd3;
	localparam logic [OFS_W-1:0] REG_ADDR3 = 9'd4;
	localparam logic [OFS_W-1:0] REG_DATA0 = 9'd5;
	localparam logic [OFS_W-1:0] REG_DATA1 = 9'd6;
	localparam logic [OFS_W-1:0] REG_DATA2 = 9'd7;
	localparam logic [OFS_W-1:0] REG_DATA3 = 9'd8;
	localparam logic [OFS_W-1:0] REG_PTR = 9'd9;
	localparam logic [OFS_W-1:0] REG_LEN = 9'd10;
	localparam logic [OFS_W-1:0] REG_CMD = 9'd11;

	// one word, byte lanes on the bus side, whole word on the app side
	typedef union packed {
		logic [WORD_W/BUS_DAT_W-1:0][BUS_DAT_W-1:0] lane;
		logic [WORD_W-1:0] word;
	} word_u;

	// sequencer state, read back as the status byte
	typedef enum logic [7:0] {
		IDLE = 8'd0,
		REQ_WR = 8'd1,
		WR = 8'd2,
		REQ_RD = 8'd3,
		RD = 8'd4
	} seq_state_e;

endpackage

`default_nettype wire

//--- src/xfer_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module xfer_buffer #(
	parameter int BUF_DEPTH = 32
) (
	input logic clk,
	input logic rst_n,
	buf_bus_if.buffer bus,
	buf_xfer_if.buffer xfer
);
	import sdram_peri_pkg::*;

	localparam int IDX_W = $clog2(BUF_DEPTH);

	// transfer buffer
	word_u mem [BUF_DEPTH];
	logic [LEN_W-1:0] ptr_q;
	logic [IDX_W-1:0] idx;

	// memory is indexed by the low pointer bits
	assign idx = ptr_q[IDX_W-1:0];

	// pointer: bus load wins, else step or fill advances
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end
		else if (bus.ptr_we) begin
			ptr_q <= bus.ptr_data;
		end
		else if (xfer.step || xfer.fill_we) begin
			ptr_q <= ptr_q + 1'b1;
		end
	end

	// whole-word fill from the controller, or one byte lane from the bus
	always_ff @(posedge clk) begin
		if (xfer.fill_we) begin
			mem[idx].word <= xfer.fill_data;
		end
		else if (bus.lane_we) begin
			mem[idx].lane[bus.lane_sel] <= bus.lane_data;
		end
	end

	// same word seen both ways
	assign bus.cur_word = mem[idx];
	assign xfer.cur_word = mem[idx].word;
	assign bus.ptr = ptr_q;
	assign xfer.ptr = ptr_q;

endmodule

`default_nettype wire

//--- src/xfer_seq.sv
`default_nettype none
`timescale 1ns/10ps

module xfer_seq (
	input logic clk,
	input logic rst_n,
	ctl_if.seq ctl,
	buf_xfer_if.seq xfer,
	// app request port
	output logic app_req,
	input logic app_req_ack,
	output logic app_req_wr_n,
	input logic app_wr_next_req,
	input logic [sdram_peri_pkg::WORD_W-1:0] app_rd_data,
	input logic app_rd_valid
);
	import sdram_peri_pkg::*;

	seq_state_e state;
	seq_state_e state_nxt;
	// all words moved
	logic done;

	assign done = (xfer.ptr >= ctl.len);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (ctl.start) begin
					state_nxt = ctl.is_read ? REQ_RD : REQ_WR;
				end
			end
			REQ_WR: begin
				if (app_req_ack) begin
					state_nxt = WR;
				end
			end
			REQ_RD: begin
				if (app_req_ack) begin
					state_nxt = RD;
				end
			end
			WR, RD: begin
				if (done) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			app_req_wr_n <= 1'b1;
		end
		else begin
			state <= state_nxt;
			// direction latched with the accepted start
			if (state == IDLE && ctl.start) begin
				app_req_wr_n <= ctl.is_read;
			end
		end
	end

	// request held up to and including the ack cycle
	assign app_req = (state == REQ_WR) || (state == REQ_RD);

	// buffer moves on each controller strobe until len is reached
	assign xfer.step = (state == WR) && app_wr_next_req && !done;
	assign xfer.fill_we = (state == RD) && app_rd_valid && !done;
	assign xfer.fill_data = app_rd_data;

	assign ctl.state = state;

endmodule

`default_nettype wire

//--- verif/sdram_peri_assert.sv
`default_nettype none
`timescale 1ns/10ps

module sdram_peri_assert (
	input logic clk,
	input logic rst_n,
	input logic app_req,
	input logic app_req_ack,
	input logic app_req_wr_n,
	input logic app_wr_next_req,
	input logic app_rd_valid,
	input sdram_peri_pkg::seq_state_e state
);
	import sdram_peri_pkg::*;

	// request drops only the cycle after ack was seen
	req_falls_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(app_req) |-> $past(app_req_ack))
		else $error("app_req dropped without an acknowledge");

	// direction steady for the whole request
	wr_n_steady: assert property (@(posedge clk) disable iff (!rst_n)
		(app_req && $past(app_req)) |-> $stable(app_req_wr_n))
		else $error("app_req_wr_n changed while app_req was high");

	// no data strobes without a transfer
	no_strobe_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == IDLE) |-> (!app_wr_next_req && !app_rd_valid))
		else $error("controller strobe arrived while the sequencer was idle");

endmodule

bind xfer_seq sdram_peri_assert i_assert (
	.clk(clk),
	.rst_n(rst_n),
	.app_req(app_req),
	.app_req_ack(app_req_ack),
	.app_req_wr_n(app_req_wr_n),
	.app_wr_next_req(app_wr_next_req),
	.app_rd_valid(app_rd_valid),
	.state(state)
);

`default_nettype wire

//--- verif/sdram_peri_tb.sv
`default_nettype none
`timescale 1ns/10ps

module sdram_peri_tb;
	import sdram_peri_pkg::*;

	localparam int BLOCK = 1;
	localparam int BLK_W = BUS_ADR_W - OFS_W;
	// block 0, decodes to nothing
	localparam logic [BUS_ADR_W-1:0] IDLE_ADR = '0;
	localparam int WAIT_LIMIT = 300;

	logic clk;
	logic rst_n;
	logic [BUS_ADR_W-1:0] adr;
	logic we;
	logic [BUS_DAT_W-1:0] dat_w;
	logic [BUS_DAT_W-1:0] dat_r;
	logic app_req;
	logic app_req_ack;
	logic app_req_wr_n;
	logic [WORD_W-1:0] app_req_addr;
	logic [LEN_W-1:0] app_req_len;
	logic [WORD_W-1:0] app_wr_data;
	logic app_wr_next_req;
	logic [WORD_W-1:0] app_rd_data;
	logic app_rd_valid;

	// controller model memory and last request seen
	logic [WORD_W-1:0] model_mem [256];
	logic [WORD_W-1:0] seen_addr;
	logic [LEN_W-1:0] seen_len;
	logic seen_wr_n;
	int req_count;

	sdram_peri i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.adr(adr),
		.we(we),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.app_req(app_req),
		.app_req_ack(app_req_ack),
		.app_req_wr_n(app_req_wr_n),
		.app_req_addr(app_req_addr),
		.app_req_len(app_req_len),
		.app_wr_data(app_wr_data),
		.app_wr_next_req(app_wr_next_req),
		.app_rd_data(app_rd_data),
		.app_rd_valid(app_rd_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [BUS_ADR_W-1:0] reg_adr(input logic [OFS_W-1:0] ofs);
		return {BLK_W'(BLOCK), ofs};
	endfunction

	// one bus cycle, then back to an undecoded read
	task automatic raw_access(input logic [BUS_ADR_W-1:0] a, input logic w, input logic [7:0] d);
		@(posedge clk);
		#1;
		adr = a;
		we = w;
		dat_w = d;
		@(posedge clk);
		#1;
		adr = IDLE_ADR;
		we = 1'b0;
		dat_w = '0;
	endtask

	task automatic write_reg(input logic [OFS_W-1:0] ofs, input logic [7:0] d);
		raw_access(reg_adr(ofs), 1'b1, d);
	endtask

	// dat_r already holds the register after the sampling edge
	task automatic read_reg(input logic [OFS_W-1:0] ofs, output logic [7:0] v);
		raw_access(reg_adr(ofs), 1'b0, 8'h00);
		v = dat_r;
	endtask

	task automatic write_addr(input logic [WORD_W-1:0] addr);
		for (int l = 0; l < 4; l++) begin
			write_reg(9'(REG_ADDR0 + l), addr[8*l +: 8]);
		end
	endtask

	// lane 0 is the low byte
	task automatic load_word(input logic [7:0] ptr, input logic [WORD_W-1:0] word);
		write_reg(REG_PTR, ptr);
		for (int l = 0; l < 4; l++) begin
			write_reg(9'(REG_DATA0 + l), word[8*l +: 8]);
		end
	endtask

	task automatic read_word(input logic [7:0] ptr, output logic [WORD_W-1:0] word);
		logic [7:0] v;
		write_reg(REG_PTR, ptr);
		for (int l = 0; l < 4; l++) begin
			read_reg(9'(REG_DATA0 + l), v);
			word[8*l +: 8] = v;
		end
	endtask

	// poll status until the sequencer is back in IDLE
	task automatic wait_status_idle();
		logic [7:0] st;
		int tries;
		tries = 0;
		read_reg(REG_STATUS, st);
		while (st != IDLE) begin
			tries++;
			if (tries > WAIT_LIMIT) begin
				$display("timeout: status register never returned to idle");
				$display("SOME TESTS FAILED");
				$fatal(1, "status wait expired");
			end
			else begin
				read_reg(REG_STATUS, st);
			end
		end
	endtask

	// controller model, answers one request
	task automatic serve_request();
		int gap;
		seen_addr = app_req_addr;
		seen_len = app_req_len;
		seen_wr_n = app_req_wr_n;
		req_count++;
		// ack after 1 to 5 cycles
		repeat ($urandom_range(5, 1)) @(posedge clk);
		#1;
		app_req_ack = 1'b1;
		@(posedge clk);
		#1;
		app_req_ack = 1'b0;
		for (int k = 0; k < int'(seen_len); k++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			if (seen_wr_n) begin
				app_rd_data = model_mem[k];
				app_rd_valid = 1'b1;
			end
			else begin
				// word at the pointer, stable until the step edge
				model_mem[k] = app_wr_data;
				app_wr_next_req = 1'b1;
			end
			@(posedge clk);
			#1;
			app_rd_valid = 1'b0;
			app_wr_next_req = 1'b0;
		end
	endtask

	initial begin
		app_req_ack = 1'b0;
		app_wr_next_req = 1'b0;
		app_rd_data = '0;
		app_rd_valid = 1'b0;
		req_count = 0;
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && app_req) begin
				serve_request();
			end
		end
	end

	task automatic reset_values();
		logic [7:0] v;
		check_value(32'(dat_r), 32'd0, "dat_r after reset");
		check_value(32'(app_req), 32'd0, "app_req after reset");
		check_value(32'(app_req_wr_n), 32'd1, "app_req_wr_n after reset");
		// data lanes show the buffer, which has no reset
		for (int o = 0; o <= 11; o++) begin
			if (o < 5 || o > 8) begin
				read_reg(9'(o), v);
				check_value(32'(v), 32'd0, $sformatf("register %0d after reset", o));
			end
		end
	endtask

	task automatic register_readback();
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] words [3];
		logic [WORD_W-1:0] got;
		logic [7:0] v;
		logic [7:0] len;
		logic [7:0] ptr;
		int ptrs [3];
		ptrs = '{3, 17, 30};
		addr = $urandom;
		len = 8'($urandom);
		ptr = 8'($urandom);
		write_addr(addr);
		write_reg(REG_LEN, len);
		write_reg(REG_PTR, ptr);
		for (int l = 0; l < 4; l++) begin
			read_reg(9'(REG_ADDR0 + l), v);
			check_value(32'(v), 32'(addr[8*l +: 8]), "address byte read-back");
		end
		read_reg(REG_LEN, v);
		check_value(32'(v), 32'(len), "length read-back");
		read_reg(REG_PTR, v);
		check_value(32'(v), 32'(ptr), "pointer read-back");
		for (int i = 0; i < 3; i++) begin
			words[i] = $urandom;
			load_word(8'(ptrs[i]), words[i]);
		end
		for (int i = 0; i < 3; i++) begin
			read_word(8'(ptrs[i]), got);
			check_value(got, words[i], "buffer word read-back");
		end
	endtask

	task automatic foreign_block_access();
		logic [7:0] a0;
		logic [7:0] len_before;
		logic [7:0] v;
		int count_before;
		count_before = req_count;
		read_reg(REG_ADDR0, a0);
		read_reg(REG_LEN, len_before);
		// dat_r now holds the length
		raw_access({BLK_W'(2), REG_LEN}, 1'b1, ~len_before);
		check_value(32'(dat_r), 32'(len_before), "dat_r after foreign length write");
		raw_access({BLK_W'(0), REG_ADDR0}, 1'b1, ~a0);
		check_value(32'(dat_r), 32'(len_before), "dat_r after foreign address write");
		raw_access({BLK_W'(31), REG_CMD}, 1'b1, 8'h01);
		check_value(32'(dat_r), 32'(len_before), "dat_r after foreign command write");
		raw_access({BLK_W'(3), REG_STATUS}, 1'b0, 8'h00);
		check_value(32'(dat_r), 32'(len_before), "dat_r after foreign read");
		check_value(32'(app_req), 32'd0, "app_req after foreign command");
		read_reg(REG_LEN, v);
		check_value(32'(v), 32'(len_before), "length after foreign writes");
		read_reg(REG_ADDR0, v);
		check_value(32'(v), 32'(a0), "address byte after foreign writes");
		read_reg(REG_STATUS, v);
		check_value(32'(v), 32'd0, "status after foreign command");
		// a foreign command must never reach the controller
		check_value(32'(req_count), 32'(count_before), "requests after foreign command");
	endtask

	task automatic write_transfer();
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] words [8];
		logic [7:0] len;
		logic [7:0] v;
		int count_before;
		len = 8'($urandom_range(8, 1));
		addr = $urandom;
		for (int k = 0; k < int'(len); k++) begin
			words[k] = $urandom;
			load_word(8'(k), words[k]);
		end
		write_addr(addr);
		write_reg(REG_LEN, len);
		count_before = req_count;
		write_reg(REG_CMD, 8'h00);
		wait_status_idle();
		check_value(32'(req_count), 32'(count_before + 1), "write request count");
		check_value(seen_addr, addr, "write request address");
		check_value(32'(seen_len), 32'(len), "write request length");
		check_value(32'(seen_wr_n), 32'd0, "write request direction");
		// words must reach the controller in pointer order
		for (int k = 0; k < int'(len); k++) begin
			check_value(model_mem[k], words[k], "word received by controller");
		end
		read_reg(REG_PTR, v);
		check_value(32'(v), 32'(len), "pointer after write transfer");
	endtask

	task automatic read_transfer();
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] got;
		logic [7:0] len;
		logic [7:0] v;
		int count_before;
		len = 8'($urandom_range(8, 1));
		addr = $urandom;
		for (int k = 0; k < int'(len); k++) begin
			model_mem[k] = $urandom;
		end
		write_addr(addr);
		write_reg(REG_LEN, len);
		count_before = req_count;
		write_reg(REG_CMD, 8'h01);
		wait_status_idle();
		check_value(32'(req_count), 32'(count_before + 1), "read request count");
		check_value(seen_addr, addr, "read request address");
		check_value(32'(seen_len), 32'(len), "read request length");
		check_value(32'(seen_wr_n), 32'd1, "read request direction");
		read_reg(REG_PTR, v);
		check_value(32'(v), 32'(len), "pointer after read transfer");
		for (int k = 0; k < int'(len); k++) begin
			read_word(8'(k), got);
			check_value(got, model_mem[k], "word stored from controller");
		end
	endtask

	initial begin
		void'($urandom(32'hc7e2));
		rst_n = 1'b0;
		adr = IDLE_ADR;
		we = 1'b0;
		dat_w = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_values();
		register_readback();
		foreign_block_access();
		repeat (2) begin
			write_transfer();
			read_transfer();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
